/* riscv_core.f */
logic/rv_pkg.sv
logic/sync_ram.sv
logic/decode.sv
logic/register_file.sv
logic/execute.sv
logic/processor.sv
sim/processor_props.sv
sim/processor_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module processor_tb -f riscv_core.f -o processor_sim &&
  ./obj_dir/processor_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qxF '** PASS **' sim.log && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

/* sim/processor_golden.mem */
# P <instruction word> | R <test> <data_out> <addr_out> <next_pc_out> | E <retired count>
# P words load from word index 0 up, R lines are the retirements in order, all hex
P 00500093
P ffd00113
P 401101b3
P 00112233
P 4041d2b3
P 12345337
P 00708013
P 001003b3
P 0030a1a3
P 0030a403
P 00340463
P 00000073
P 00208463
P 00209463
P 00000073
P 00109463
P 00114463
P 00000073
P 0020c463
P 0020d463
P 00000073
P 00115463
P 008004ef
P 00000073
P 00000073
R 1 00000005 00000005 00000004
R 2 fffffffd 00000001 00000008
R 2 fffffff8 00000008 0000000c
R 2 00000001 0000000c 00000010
R 2 fffffffc 00000010 00000014
R 2 12345000 12345014 00000018
R 2 0000000c 0000001f 0000001c
R 2 00000005 0000001c 00000020
R 3 fffffff8 00000008 00000024
R 3 fffffff8 00000008 00000028
R 4 fffffff0 00000030 00000030
R 4 00000002 00000038 00000034
R 4 a0000000 0000003c 0000003c
R 4 000000a0 00000044 00000040
R 4 fffffff8 00000048 00000048
R 4 fffffff8 00000050 0000004c
R 4 00000000 00000054 00000054
R 4 07ffffff 0000005c 00000058
R 4 0000005c 00000060 00000060
R 5 00000000 00000060 00000064
E 20

/* sim/processor_tb.sv */
`timescale 1ns/1ps

module processor_tb import rv_pkg::*; ();

  logic               clk_100mhz;
  logic               rst_in;
  logic               load_valid;
  logic [IMEM_AW-1:0] load_addr;
  word_t              load_data;
  logic               load_last;
  logic               load_ready;
  logic               retire_valid;
  word_t              data_out;
  addr_t              addr_out;
  addr_t              next_pc_out;
  logic               halted;

  // Golden program and retire trace
  word_t prog_q[$];
  int    exp_test_q[$];                  // Test number of each retirement
  word_t exp_data_q[$];
  addr_t exp_addr_q[$];
  addr_t exp_next_q[$];
  int    exp_count;

  int checks, errors, cur_test, retired;
  int cycle_cnt, cycle_limit;            // Watchdog stays off while the limit is 0
  int t_checks[1:5];
  int t_errors[1:5];

  processor UUT (
    .clk_100mhz(clk_100mhz), .rst_in(rst_in), .load_valid(load_valid),
    .load_addr(load_addr), .load_data(load_data), .load_last(load_last),
    .load_ready(load_ready), .retire_valid(retire_valid), .data_out(data_out),
    .addr_out(addr_out), .next_pc_out(next_pc_out), .halted(halted)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz; // 100 MHz
  end

  always @(posedge clk_100mhz) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the core never finished", cycle_cnt);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic string test_name(input int t);
    case (t)
      1:       return "load_handshake";
      2:       return "alu_ops";
      3:       return "store_load";
      4:       return "branch_jump";
      default: return "halt";
    endcase
  endfunction

  task automatic note_error();
    errors++;
    t_errors[cur_test]++;
  endtask

  task automatic compare_word(input string what, input word_t exp, input word_t act);
    checks++;
    t_checks[cur_test]++;
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name(cur_test), what, exp, act);
      note_error();
    end
  endtask

  task automatic compare_addr(input string what, input addr_t exp, input addr_t act);
    checks++;
    t_checks[cur_test]++;
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name(cur_test), what, exp, act);
      note_error();
    end
  endtask

  task automatic compare_count(input string what, input int exp, input int act);
    checks++;
    t_checks[cur_test]++;
    if (act != exp) begin
      $display("MISMATCH %s %s: expected %0d, actual %0d", test_name(cur_test), what, exp, act);
      note_error();
    end
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %0d checks, %0d errors, %s", t, test_name(t),
             t_checks[t], t_errors[t], (t_errors[t] == 0) ? "ok" : "failed");
  endtask

  // Records are P word, R test data addr next_pc, E count; # starts a comment
  task automatic read_golden(output bit opened);
    int fd, n, t;
    logic [7:0] tag;
    logic [8*160-1:0] line_buf;
    word_t w, d;
    addr_t a, nx;
    bit more;
    fd     = $fopen("sim/processor_golden.mem", "r");
    opened = (fd != 0);
    if (opened) begin
      more = 1'b1;
      while (more) begin
        n = $fscanf(fd, " %c", tag);
        if (n != 1) begin
          more = 1'b0;                   // End of file
        end else begin
          case (tag)
            "#": n = $fgets(line_buf, fd);
            "P": begin
              n = $fscanf(fd, "%h", w);
              prog_q.push_back(w);
            end
            "R": begin
              n = $fscanf(fd, "%d %h %h %h", t, d, a, nx);
              exp_test_q.push_back(t);
              exp_data_q.push_back(d);
              exp_addr_q.push_back(a);
              exp_next_q.push_back(nx);
            end
            "E": n = $fscanf(fd, "%d", exp_count);
            default: begin
              $display("Unknown record type in the golden file");
              note_error();
            end
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic load_program();
    int gap, waited, accepted;
    accepted = 0;
    for (int i = 0; i < prog_q.size(); i++) begin
      gap = $urandom % 3;                // 0 to 2 idle cycles
      repeat (gap) @(negedge clk_100mhz);
      load_valid = 1'b1;
      load_addr  = IMEM_AW'(i);
      load_data  = prog_q[i];
      load_last  = (i == prog_q.size() - 1);
      waited = 0;
      while (!load_ready && waited < 8) begin
        @(negedge clk_100mhz);
        waited++;
      end
      if (load_ready) begin
        accepted++;
      end else begin
        $display("Program word %0d was never accepted", i);
        note_error();
      end
      @(negedge clk_100mhz);             // Taken on the rising edge just passed
      load_valid = 1'b0;
      load_last  = 1'b0;
    end
    compare_count("words accepted", prog_q.size(), accepted);
    if (load_ready) begin
      $display("load_ready still high after the last program word");
      note_error();
    end
  endtask

  task automatic score_retirement(input int idx);
    if (idx >= exp_data_q.size()) begin
      $display("Retirement %0d with next PC %h has no golden entry", idx, next_pc_out);
      note_error();
    end else begin
      if (exp_test_q[idx] != cur_test) begin
        report_test(cur_test);           // Previous test is complete
        cur_test = exp_test_q[idx];
      end
      compare_word($sformatf("retire %0d data_out", idx), exp_data_q[idx], data_out);
      compare_addr($sformatf("retire %0d addr_out", idx), exp_addr_q[idx], addr_out);
      compare_addr($sformatf("retire %0d next_pc_out", idx), exp_next_q[idx], next_pc_out);
    end
  endtask

  task automatic watch_retirements();
    retired = 0;
    while (!halted) begin
      @(negedge clk_100mhz);
      if (retire_valid) begin
        score_retirement(retired);
        retired++;
      end
    end
    if (retired < exp_data_q.size()) begin
      $display("Core halted after %0d retirements, %0d were expected",
               retired, exp_data_q.size());
      note_error();
    end
  endtask

  task automatic observe_halt();
    int extra;
    bit dropped;
    extra   = 0;
    dropped = 1'b0;
    if (cur_test != 5) begin
      report_test(cur_test);
      cur_test = 5;
    end
    repeat (20) begin
      @(negedge clk_100mhz);
      if (retire_valid) extra++;
      if (!halted) dropped = 1'b1;
    end
    if (extra != 0) begin
      $display("%0d retire pulses came after the halt", extra);
      note_error();
    end
    if (dropped) begin
      $display("halted went low after the ECALL retired");
      note_error();
    end
    compare_count("retired count", exp_count, retired + extra);
    report_test(cur_test);
  endtask

  initial begin
    bit opened;
    void'($urandom(32'h07ba_0c65));     // Seed for the load gaps
    rst_in      = 1'b1;
    load_valid  = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    load_last   = 1'b0;
    checks      = 0;
    errors      = 0;
    cur_test    = 1;
    retired     = 0;
    exp_count   = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    for (int t = 1; t <= 5; t++) begin
      t_checks[t] = 0;
      t_errors[t] = 0;
    end
    read_golden(opened);
    if (!opened) begin
      $display("Cannot open sim/processor_golden.mem");
      $display("** FAIL **");
    end else begin
      cycle_limit = 10 * exp_data_q.size() + 4 * prog_q.size() + 50;
      repeat (4) @(posedge clk_100mhz);  // Reset for 4 cycles
      @(negedge clk_100mhz);
      rst_in = 1'b0;
      load_program();
      watch_retirements();
      observe_halt();
      $display("Done: %0d checks, %0d errors, %0d of %0d retirements seen",
               checks, errors, retired, exp_data_q.size());
      if (errors == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
    end
    $finish;
  end

endmodule

/* sim/processor_props.sv */
`timescale 1ns/1ps

// Load, retire and halt properties of the processor
module processor_props (
  input logic clk_100mhz,
  input logic rst_in,
  input logic load_valid,
  input logic load_last,
  input logic load_ready,
  input logic retire_valid,
  input logic halted
);

  logic loaded;                          // Last program word has been taken

  always_ff @(posedge clk_100mhz) begin
    if (rst_in) begin
      loaded <= 1'b0;
    end else if (load_valid && load_ready && load_last) begin
      loaded <= 1'b1;
    end
  end

  // Nothing retires until the last program word is accepted
  no_retire_in_load: assert property (@(posedge clk_100mhz) disable iff (rst_in)
    retire_valid |-> loaded && !load_ready)
    else $error("retire_valid high before the program finished loading");

  halt_sticky: assert property (@(posedge clk_100mhz) disable iff (rst_in)
    halted |=> halted)                   // Only reset clears it
    else $error("halted dropped without a reset");

  // Load port closes for good once the last word is in
  load_closed: assert property (@(posedge clk_100mhz) disable iff (rst_in)
    !load_ready |=> !load_ready)
    else $error("load_ready rose again after loading ended");

  retire_spacing: assert property (@(posedge clk_100mhz) disable iff (rst_in)
    retire_valid |-> !$past(retire_valid, 1) && !$past(retire_valid, 2) &&
                     !$past(retire_valid, 3) && !$past(retire_valid, 4))
    else $error("two retire pulses less than 5 cycles apart");

endmodule

bind processor processor_props props (
  .clk_100mhz(clk_100mhz), .rst_in(rst_in), .load_valid(load_valid),
  .load_last(load_last), .load_ready(load_ready),
  .retire_valid(retire_valid), .halted(halted)
);

/* logic/processor.sv */
`timescale 1ns/1ps

module processor import rv_pkg::*; (
  input  logic               clk_100mhz,
  input  logic               rst_in,
  input  logic               load_valid,
  input  logic [IMEM_AW-1:0] load_addr,  // Word index
  input  word_t              load_data,
  input  logic               load_last,
  output logic               load_ready,
  output logic               retire_valid,
  output word_t              data_out,
  output addr_t              addr_out,
  output addr_t              next_pc_out,
  output logic               halted
);

  typedef enum logic [2:0] {
    S_LOAD, S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK, S_HALT
  } state_e;

  state_e state;
  logic   wait_cnt;                      // Second cycle of fetch or load wait
  addr_t  pc;
  inst_u  ir;
  inst_u  fetched;
  inst_u  dec_in;

  logic [IMEM_AW-1:0] imem_addr;
  logic               imem_we;
  word_t              imem_dout;
  logic [DMEM_AW-1:0] dmem_addr;
  logic               dmem_we;
  word_t              dmem_dout;

  itype_e    itype;
  alu_func_e alu_func;
  br_func_e  br_func;
  word_t     imm;
  reg_idx_t  rs1, rs2, rd;
  word_t     rval1, rval2;
  word_t     result;
  addr_t     mem_addr;
  addr_t     next_pc;
  word_t     wd;
  logic      rf_we;

  // Instruction RAM is shared by the load port and fetch
  assign load_ready = (state == S_LOAD);
  assign imem_we    = load_valid && load_ready;
  assign imem_addr  = load_ready ? load_addr : pc[IMEM_AW+1:2];
  assign fetched    = imem_dout;

  sync_ram #(.DEPTH(IMEM_DEPTH), .AW(IMEM_AW)) inst_mem (
    .clk_100mhz(clk_100mhz), .rst_in(rst_in), .addr(imem_addr),
    .din(load_data), .we(imem_we), .dout(imem_dout)
  );

  // Fresh word straight from RAM in DECODE, held copy afterwards
  assign dec_in = (state == S_DECODE) ? fetched : ir;

  decode decoder (
    .clk_100mhz(clk_100mhz), .rst_in(rst_in), .instruction(dec_in),
    .itype(itype), .alu_func(alu_func), .br_func(br_func), .imm(imm),
    .rs1(rs1), .rs2(rs2), .rd(rd)
  );

  register_file registers (
    .clk_100mhz(clk_100mhz), .rst_in(rst_in), .rs1(rs1), .rs2(rs2),
    .wa(rd), .we(rf_we), .wd(wd), .rd1(rval1), .rd2(rval2)
  );

  execute alu_unit (
    .itype(itype), .alu_func(alu_func), .br_func(br_func), .imm(imm), .pc(pc),
    .rval1(rval1), .rval2(rval2), .data(result), .addr(mem_addr), .next_pc(next_pc)
  );

  assign dmem_addr = mem_addr[DMEM_AW+1:2];
  assign dmem_we   = (state == S_MEMORY) && (itype == STORE);

  sync_ram #(.DEPTH(DMEM_DEPTH), .AW(DMEM_AW)) data_mem (
    .clk_100mhz(clk_100mhz), .rst_in(rst_in), .addr(dmem_addr),
    .din(result), .we(dmem_we), .dout(dmem_dout)
  );

  // Writeback select: memory word, link address, or ALU result
  always_comb begin
    case (itype)
      LOAD:    wd = dmem_dout;
      JAL:     wd = word_t'(pc + 32'd4);
      default: wd = result;
    endcase
  end

  assign rf_we = (state == S_WRITEBACK) && (rd != '0) &&
                 !(itype inside {BRANCH, STORE, SYSTEM, NOP});

  // Retire trace; data_out shows what gets written back
  assign retire_valid = (state == S_WRITEBACK);
  assign data_out     = wd;
  assign addr_out     = mem_addr;
  assign next_pc_out  = next_pc;
  assign halted       = (state == S_HALT) || (retire_valid && itype == SYSTEM);

  always_ff @(posedge clk_100mhz) begin
    if (rst_in) begin
      state    <= S_LOAD;
      wait_cnt <= 1'b0;
      pc       <= '0;
      ir       <= '0;                    // Decodes as NOP while loading
    end else begin
      case (state)
        S_LOAD: if (imem_we && load_last) begin
          state    <= S_FETCH;
          pc       <= '0;
          wait_cnt <= 1'b0;
        end
        S_FETCH: begin                   // Two cycles of RAM latency
          wait_cnt <= !wait_cnt;
          if (wait_cnt) state <= S_DECODE;
        end
        S_DECODE: begin
          ir <= fetched;
          // Stores skip straight to the memory cycle, raw opcode is all we have yet
          state <= (fetched.r.opcode == OPC_STORE) ? S_MEMORY : S_EXECUTE;
        end
        S_EXECUTE: state <= (itype == LOAD) ? S_MEMORY : S_WRITEBACK;
        S_MEMORY: begin
          if (itype == LOAD && !wait_cnt) begin
            wait_cnt <= 1'b1;            // Hold one more cycle for read data
          end else begin
            wait_cnt <= 1'b0;
            state    <= S_WRITEBACK;
          end
        end
        S_WRITEBACK: begin
          pc    <= next_pc;
          state <= (itype == SYSTEM) ? S_HALT : S_FETCH;
        end
        default: state <= S_HALT;        // Parked until reset
      endcase
    end
  end

endmodule

/* logic/execute.sv */
`timescale 1ns/1ps

// ALU, branch compare and next PC, all combinational
module execute import rv_pkg::*; (
  input  itype_e    itype,
  input  alu_func_e alu_func,
  input  br_func_e  br_func,
  input  word_t     imm,
  input  addr_t     pc,
  input  word_t     rval1,
  input  word_t     rval2,
  output word_t     data,
  output addr_t     addr,
  output addr_t     next_pc
);

  word_t opb;
  word_t alu;
  logic  taken;
  logic  is_mem;
  addr_t pc_plus4;
  addr_t target;

  // Second operand: register for OP and branches, immediate otherwise
  assign opb = (itype == OP || itype == BRANCH) ? rval2 : imm;

  always_comb begin
    case (alu_func)
      ADD:     alu = rval1 + opb;
      SUB:     alu = rval1 - opb;
      AND:     alu = rval1 & opb;
      OR:      alu = rval1 | opb;
      XOR:     alu = rval1 ^ opb;
      SLT:     alu = (rval1 < opb) ? 32'sd1 : 32'sd0; // Signed compare
      SLL:     alu = rval1 << opb[4:0];
      SRL:     alu = $signed($unsigned(rval1) >> opb[4:0]);
      SRA:     alu = rval1 >>> opb[4:0];
      default: alu = rval1 + opb;
    endcase
  end

  always_comb begin
    case (br_func)
      EQ:      taken = (rval1 == rval2);
      NE:      taken = (rval1 != rval2);
      LT:      taken = (rval1 < rval2);
      GE:      taken = (rval1 >= rval2);
      default: taken = 1'b0;
    endcase
  end

  assign is_mem   = (itype == LOAD) || (itype == STORE);
  assign pc_plus4 = pc + 32'd4;
  assign target   = pc + addr_t'(imm);

  // Loads and stores carry store data; LUI just forwards its immediate
  assign data = is_mem ? rval2 : (itype == LUI) ? imm : alu;
  assign addr = is_mem ? addr_t'(rval1 + imm) : target; // Effective address or target

  always_comb begin
    if (itype == JAL || (itype == BRANCH && taken)) next_pc = target;
    else next_pc = pc_plus4;
  end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
  input  logic     clk_100mhz,
  input  logic     rst_in,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t wa,
  input  logic     we,
  input  word_t    wd,
  output word_t    rd1,
  output word_t    rd2
);

  word_t regs [32];

  // Combinational reads, x0 hardwired
  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk_100mhz) begin
    if (rst_in) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (we && wa != '0) begin
      regs[wa] <= wd;                    // Readable from the next cycle
    end
  end

endmodule

/* logic/decode.sv */
`timescale 1ns/1ps

module decode import rv_pkg::*; (
  input  logic      clk_100mhz,
  input  logic      rst_in,
  input  inst_u     instruction,
  output itype_e    itype,
  output alu_func_e alu_func,
  output br_func_e  br_func,
  output word_t     imm,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  output reg_idx_t  rd
);

  itype_e    itype_n;
  alu_func_e alu_n;
  br_func_e  br_n;
  word_t     imm_n;
  word_t     imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [2:0] f3;
  logic       alt;                       // funct7 bit 5, picks SUB / SRA

  assign f3  = instruction.r.funct3;
  assign alt = instruction.r.funct7[5];

  // Immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instruction.i.imm[11]}}, instruction.i.imm};
  assign imm_s = {{20{instruction.r.funct7[6]}}, instruction.r.funct7, instruction.r.rd};
  assign imm_b = {{19{instruction.r.funct7[6]}}, instruction.r.funct7[6], instruction.r.rd[0],
                  instruction.r.funct7[5:0], instruction.r.rd[4:1], 1'b0};
  assign imm_j = {{11{instruction.i.imm[11]}}, instruction.i.imm[11], instruction.i.rs1,
                  instruction.i.funct3, instruction.i.imm[0], instruction.i.imm[10:1], 1'b0};
  assign imm_u = {instruction.i.imm, instruction.i.rs1, instruction.i.funct3, 12'b0};

  always_comb begin
    itype_n = NOP;                       // Anything unrecognized retires as a no-op
    br_n    = EQ;
    imm_n   = '0;
    case (f3)                            // Shared funct3 map for OP and OP_IMM
      3'b000:  alu_n = (alt && instruction.r.opcode == OPC_OP) ? SUB : ADD;
      3'b001:  alu_n = SLL;
      3'b010:  alu_n = SLT;
      3'b100:  alu_n = XOR;
      3'b101:  alu_n = alt ? SRA : SRL;
      3'b110:  alu_n = OR;
      3'b111:  alu_n = AND;
      default: alu_n = ADD;              // SLTU, not supported
    endcase
    case (instruction.r.opcode)
      OPC_OP:     if (f3 != 3'b011) itype_n = OP;
      OPC_OP_IMM: begin
        if (f3 != 3'b011) itype_n = OP_IMM;
        imm_n = imm_i;
      end
      OPC_LOAD: begin
        if (f3 == F3_WORD) itype_n = LOAD; // Word accesses only
        imm_n = imm_i;
      end
      OPC_STORE: begin
        if (f3 == F3_WORD) itype_n = STORE;
        imm_n = imm_s;
      end
      OPC_BRANCH: begin
        imm_n   = imm_b;
        itype_n = BRANCH;
        case (f3)
          3'b000:  br_n = EQ;
          3'b001:  br_n = NE;
          3'b100:  br_n = LT;
          3'b101:  br_n = GE;
          default: itype_n = NOP;        // Unsigned compares left out
        endcase
      end
      OPC_JAL: begin
        itype_n = JAL;
        imm_n   = imm_j;
      end
      OPC_LUI: begin
        itype_n = LUI;
        imm_n   = imm_u;
      end
      OPC_SYSTEM: if (instruction == ECALL_WORD) itype_n = SYSTEM;
      default: itype_n = NOP;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (rst_in) begin
      itype    <= NOP;
      alu_func <= ADD;
      br_func  <= EQ;
      imm      <= '0;
      rs1      <= '0;
      rs2      <= '0;
      rd       <= '0;
    end else begin
      itype    <= itype_n;
      alu_func <= alu_n;
      br_func  <= br_n;
      imm      <= imm_n;
      rs1      <= instruction.r.rs1;
      rs2      <= instruction.r.rs2;
      rd       <= instruction.r.rd;
    end
  end

endmodule

/* logic/sync_ram.sv */
`timescale 1ns/1ps

// Single-port RAM, read-first, with an extra output stage
module sync_ram import rv_pkg::*; #(
  parameter int DEPTH = IMEM_DEPTH,
  parameter int AW    = IMEM_AW
) (
  input  logic          clk_100mhz,
  input  logic          rst_in,
  input  logic [AW-1:0] addr,
  input  word_t         din,
  input  logic          we,
  output word_t         dout
);

  word_t mem [DEPTH];
  word_t rd_q;                           // First read stage

  always_ff @(posedge clk_100mhz) begin
    if (we) mem[addr] <= din;            // Array itself keeps its contents on reset
  end

  always_ff @(posedge clk_100mhz) begin
    if (rst_in) begin
      rd_q <= '0;
      dout <= '0;
    end else begin
      rd_q <= mem[addr];                 // Old word when writing the same address
      dout <= rd_q;                      // Second stage, two cycles after addr
    end
  end

endmodule

/* logic/rv_pkg.sv */
package rv_pkg;

  // Basic word types
  typedef logic signed [31:0] word_t;    // Register and memory data
  typedef logic [31:0] addr_t;           // Byte address and PC
  typedef logic [4:0] reg_idx_t;

  // One instruction word, two field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;                  // inst[31:20]
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } i;
  } inst_u;

  typedef enum logic [3:0] {
    OP, OP_IMM, LOAD, STORE, BRANCH, JAL, LUI, SYSTEM, NOP
  } itype_e;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, SRA
  } alu_func_e;

  typedef enum logic [2:0] {
    EQ, NE, LT, GE
  } br_func_e;

  // RV32I major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [31:0] ECALL_WORD = 32'h0000_0073; // Only SYSTEM word we accept
  localparam logic [2:0]  F3_WORD    = 3'b010;        // LW / SW width code

  // Memory sizes, in 32-bit words
  localparam int IMEM_DEPTH = 128;
  localparam int DMEM_DEPTH = 1024;
  localparam int IMEM_AW    = 7;
  localparam int DMEM_AW    = 10;

endpackage
